// ==== src/dcache_macros.svh ====
// data cache geometry: way count, set count, address and data field widths
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// tree pseudo-LRU is built for exactly four ways
`define DC_NUM_WAY 4
`define DC_NUM_IDX 8

// address split into tag, set index and byte offset
`define DC_IDX_W 3
`define DC_OFS_W 3
`define DC_TAG_W 10
`define DC_ADDR_W 16

// one 64-bit word per line
`define DC_DATA_W 64

`endif

// ==== src/dcache_pkg.sv ====
// data cache package: way number type, address union, cache line struct
`include "dcache_macros.svh"

package dcache_pkg;

  typedef logic [$clog2(`DC_NUM_WAY)-1:0] way_idx_t;

  // address fields with the tag in the upper bits
  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_IDX_W-1:0] set_index;
    logic [`DC_OFS_W-1:0] offset;
  } cache_addr_fld_t;

  // one address word, either as raw bits or split into fields
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    cache_addr_fld_t       fld;
  } cache_addr_u;

  typedef struct packed {
    logic                  valid;
    logic                  dirty;
    logic [`DC_TAG_W-1:0]  tag;
    logic [`DC_DATA_W-1:0] data;
  } cache_line_t;

endpackage

// ==== src/dcache_ifs.sv ====
// data cache interfaces: registered request bundle and per-way lookup arrays
`timescale 1ns/1ns
`include "dcache_macros.svh"

interface dcache_req_if import dcache_pkg::*; ();

  logic                  rd_search;
  cache_addr_u           rd_addr;
  logic                  wr_en;
  logic                  wr_from_mem;
  logic                  wr_search;
  cache_addr_u           wr_addr;
  logic [`DC_DATA_W-1:0] wr_data;
  logic                  wr_dirty;
  logic                  wr_valid;

  modport source (
    output rd_search, rd_addr, wr_en, wr_from_mem, wr_search,
    output wr_addr, wr_data, wr_dirty, wr_valid
  );

  modport sink (
    input rd_search, rd_addr, wr_en, wr_from_mem, wr_search,
    input wr_addr, wr_data, wr_dirty, wr_valid
  );

endinterface

interface dcache_lookup_if import dcache_pkg::*; ();

  // one entry per way
  logic [`DC_NUM_WAY-1:0]                 rd_hit_way;
  logic [`DC_NUM_WAY-1:0][`DC_DATA_W-1:0] rd_data_way;
  logic [`DC_NUM_WAY-1:0]                 wr_hit_way;
  cache_line_t [`DC_NUM_WAY-1:0]          set_line_way;
  way_idx_t                               victim_way;

  modport sink (
    input rd_hit_way, rd_data_way, wr_hit_way, set_line_way, victim_way
  );

endinterface

// ==== src/dcache_req_stage.sv ====
// data cache request stage: registers request strobes, addresses and write payload
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_req_stage import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rd_search,
  input  cache_addr_u           rd_addr,
  input  logic                  wr_en,
  input  logic                  wr_from_mem,
  input  logic                  wr_search,
  input  cache_addr_u           wr_addr,
  input  logic [`DC_DATA_W-1:0] wr_data,
  input  logic                  wr_dirty,
  input  logic                  wr_valid,
  dcache_req_if.source          req
);

  // strobes cleared on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      req.rd_search <= 1'b0;
      req.wr_en     <= 1'b0;
      req.wr_search <= 1'b0;
    end else begin
      req.rd_search <= rd_search;
      req.wr_en     <= wr_en;
      req.wr_search <= wr_search;
    end
  end

  // request payload
  always_ff @(posedge clock) begin
    req.rd_addr     <= rd_addr;
    req.wr_from_mem <= wr_from_mem;
    req.wr_addr     <= wr_addr;
    req.wr_data     <= wr_data;
    req.wr_dirty    <= wr_dirty;
    req.wr_valid    <= wr_valid;
  end

endmodule

// ==== src/dcache_way.sv ====
// data cache way: line storage, read and write tag compare, line at the write set
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_way import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  dcache_req_if.sink            req,
  input  logic                  wr_en_way,
  output logic                  rd_hit,
  output logic [`DC_DATA_W-1:0] rd_data,
  output logic                  wr_hit,
  output cache_line_t           set_line
);

  cache_line_t          lines [`DC_NUM_IDX];
  cache_line_t          rd_line;
  logic [`DC_IDX_W-1:0] rd_idx;
  logic [`DC_IDX_W-1:0] wr_idx;

  assign rd_idx = req.rd_addr.fld.set_index;
  assign wr_idx = req.wr_addr.fld.set_index;

  // read side lookup
  assign rd_line = lines[rd_idx];
  assign rd_hit  = rd_line.valid && (rd_line.tag == req.rd_addr.fld.tag);
  assign rd_data = rd_line.data;

  // write side lookup and eviction candidate
  assign set_line = lines[wr_idx];
  assign wr_hit   = set_line.valid && (set_line.tag == req.wr_addr.fld.tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DC_NUM_IDX; i++) begin
        lines[i] <= '0;
      end
    end else if (wr_en_way) begin
      // a write with wr_valid low drops the line
      lines[wr_idx].valid <= req.wr_valid;
      lines[wr_idx].dirty <= req.wr_dirty;
      lines[wr_idx].tag   <= req.wr_addr.fld.tag;
      lines[wr_idx].data  <= req.wr_data;
    end
  end

endmodule

// ==== src/dcache_replace.sv ====
// data cache replacement: per-set tree pseudo-LRU, victim choice, way write enables
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_replace import dcache_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  dcache_req_if.sink             req,
  input  logic [`DC_NUM_WAY-1:0] wr_hit_way,
  output way_idx_t               victim_way,
  output logic [`DC_NUM_WAY-1:0] wr_en_way
);

  // bit a picks the half, b the way in 0/1 and c the way in 2/3
  logic [`DC_NUM_IDX-1:0] tree_a;
  logic [`DC_NUM_IDX-1:0] tree_b;
  logic [`DC_NUM_IDX-1:0] tree_c;
  logic [`DC_IDX_W-1:0]   set_idx;
  logic                   a_bit;
  logic                   hit_any;
  logic                   fill_miss;

  assign set_idx   = req.wr_addr.fld.set_index;
  assign a_bit     = tree_a[set_idx];
  assign hit_any   = |wr_hit_way;
  assign fill_miss = req.wr_en && req.wr_from_mem && !hit_any;

  assign victim_way = a_bit ? {1'b1, tree_c[set_idx]} : {1'b0, tree_b[set_idx]};

  // hit wins; otherwise only a fill places a line
  always_comb begin
    wr_en_way = '0;
    if (req.wr_en && hit_any) begin
      wr_en_way = wr_hit_way;
    end else if (fill_miss) begin
      wr_en_way[victim_way] = 1'b1;
    end
  end

  // tree moves on fill misses only
  always_ff @(posedge clock) begin
    if (reset) begin
      tree_a <= '0;
      tree_b <= '0;
      tree_c <= '0;
    end else if (fill_miss) begin
      tree_a[set_idx] <= ~a_bit;
      if (a_bit) begin
        tree_c[set_idx] <= ~tree_c[set_idx];
      end else begin
        tree_b[set_idx] <= ~tree_b[set_idx];
      end
    end
  end

endmodule

// ==== src/dcache_result_stage.sv ====
// data cache result stage: hit merge, read data select, evict line select, output registers
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_result_stage import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  dcache_req_if.sink            req,
  dcache_lookup_if.sink         look,
  output logic                  rd_hit,
  output logic [`DC_DATA_W-1:0] rd_data,
  output logic                  wr_hit,
  output logic                  evict_valid,
  output logic                  evict_dirty,
  output cache_addr_u           evict_addr,
  output logic [`DC_DATA_W-1:0] evict_data
);

  logic                  rd_hit_d;
  logic [`DC_DATA_W-1:0] rd_data_d;
  logic                  wr_hit_d;
  logic                  fill_miss;
  cache_line_t           victim_line;
  logic                  evict_valid_d;
  cache_addr_u           evict_addr_d;

  // read data is zero unless a way hits
  always_comb begin
    rd_hit_d  = 1'b0;
    rd_data_d = '0;
    for (int i = 0; i < `DC_NUM_WAY; i++) begin
      if (req.rd_search && look.rd_hit_way[i]) begin
        rd_hit_d  = 1'b1;
        rd_data_d = look.rd_data_way[i];
      end
    end
  end

  assign wr_hit_d = req.wr_search && (|look.wr_hit_way);

  // fill miss replaces the victim, which may hold a valid line
  assign fill_miss     = req.wr_en && req.wr_from_mem && !(|look.wr_hit_way);
  assign victim_line   = look.set_line_way[look.victim_way];
  assign evict_valid_d = fill_miss && victim_line.valid;

  // line address of the evicted entry with zero offset
  always_comb begin
    evict_addr_d = '0;
    if (evict_valid_d) begin
      evict_addr_d.fld.tag       = victim_line.tag;
      evict_addr_d.fld.set_index = req.wr_addr.fld.set_index;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_hit      <= 1'b0;
      wr_hit      <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      rd_hit      <= rd_hit_d;
      wr_hit      <= wr_hit_d;
      evict_valid <= evict_valid_d;
    end
  end

  // read data and evicted line outputs
  always_ff @(posedge clock) begin
    rd_data     <= rd_data_d;
    evict_dirty <= evict_valid_d && victim_line.dirty;
    evict_addr  <= evict_addr_d;
    evict_data  <= evict_valid_d ? victim_line.data : '0;
  end

endmodule

// ==== src/dcache_top.sv ====
// data cache top level: request stage, four ways, replacement and result stage
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rd_search,
  input  logic [`DC_ADDR_W-1:0] rd_addr,
  input  logic                  wr_en,
  input  logic                  wr_from_mem,
  input  logic                  wr_search,
  input  logic [`DC_ADDR_W-1:0] wr_addr,
  input  logic [`DC_DATA_W-1:0] wr_data,
  input  logic                  wr_dirty,
  input  logic                  wr_valid,
  output logic                  rd_hit,
  output logic [`DC_DATA_W-1:0] rd_data,
  output logic                  wr_hit,
  output logic                  evict_valid,
  output logic                  evict_dirty,
  output logic [`DC_ADDR_W-1:0] evict_addr,
  output logic [`DC_DATA_W-1:0] evict_data
);

  cache_addr_u            rd_addr_u;
  cache_addr_u            wr_addr_u;
  cache_addr_u            evict_addr_u;
  logic [`DC_NUM_WAY-1:0] wr_en_way;

  dcache_req_if    req_if ();
  dcache_lookup_if look_if ();

  // raw view at the pins
  assign rd_addr_u.raw = rd_addr;
  assign wr_addr_u.raw = wr_addr;
  assign evict_addr    = evict_addr_u.raw;

  dcache_req_stage u_req_stage (
    .clock       (clock),
    .reset       (reset),
    .rd_search   (rd_search),
    .rd_addr     (rd_addr_u),
    .wr_en       (wr_en),
    .wr_from_mem (wr_from_mem),
    .wr_search   (wr_search),
    .wr_addr     (wr_addr_u),
    .wr_data     (wr_data),
    .wr_dirty    (wr_dirty),
    .wr_valid    (wr_valid),
    .req         (req_if.source)
  );

  for (genvar g = 0; g < `DC_NUM_WAY; g++) begin : g_way
    dcache_way u_way (
      .clock     (clock),
      .reset     (reset),
      .req       (req_if.sink),
      .wr_en_way (wr_en_way[g]),
      .rd_hit    (look_if.rd_hit_way[g]),
      .rd_data   (look_if.rd_data_way[g]),
      .wr_hit    (look_if.wr_hit_way[g]),
      .set_line  (look_if.set_line_way[g])
    );
  end

  dcache_replace u_replace (
    .clock      (clock),
    .reset      (reset),
    .req        (req_if.sink),
    .wr_hit_way (look_if.wr_hit_way),
    .victim_way (look_if.victim_way),
    .wr_en_way  (wr_en_way)
  );

  dcache_result_stage u_result_stage (
    .clock       (clock),
    .reset       (reset),
    .req         (req_if.sink),
    .look        (look_if.sink),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_hit      (wr_hit),
    .evict_valid (evict_valid),
    .evict_dirty (evict_dirty),
    .evict_addr  (evict_addr_u),
    .evict_data  (evict_data)
  );

endmodule

// ==== test/dcache_asserts.sv ====
// data cache assertions: known outputs, hit and evict causality, one-hot way write enables
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_asserts (
  input logic                   clock,
  input logic                   reset,
  input logic                   rd_search,
  input logic                   wr_en,
  input logic                   wr_from_mem,
  input logic                   rd_hit,
  input logic [`DC_DATA_W-1:0]  rd_data,
  input logic                   wr_hit,
  input logic                   evict_valid,
  input logic                   evict_dirty,
  input logic [`DC_ADDR_W-1:0]  evict_addr,
  input logic [`DC_DATA_W-1:0]  evict_data,
  input logic [`DC_NUM_WAY-1:0] wr_en_way
);

  a_outputs_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({rd_hit, rd_data, wr_hit, evict_valid, evict_dirty, evict_addr, evict_data}))
    else $error("cache outputs unknown after reset");

  // inputs reach the outputs two sampling edges later
  a_hit_needs_search: assert property (@(posedge clock) disable iff (reset)
    rd_hit |-> $past(rd_search, 2))
    else $error("rd_hit without a read search");

  a_evict_needs_fill: assert property (@(posedge clock) disable iff (reset)
    evict_valid |-> ($past(wr_en, 2) && $past(wr_from_mem, 2)))
    else $error("evict_valid without a fill request");

  a_one_way_written: assert property (@(posedge clock) $onehot0(wr_en_way))
    else $error("more than one way write enable");

endmodule

// ==== test/dcache_tb.sv ====
// data cache testbench: reference model, directed and random stimulus, output compare, timeout
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_tb import dcache_pkg::*; ();

  localparam int NUM_OPS        = 340;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 8 * NUM_OPS + RESET_CYCLES;

  // outputs expected two edges after the request is driven
  typedef struct packed {
    logic                  rd_hit;
    logic [`DC_DATA_W-1:0] rd_data;
    logic                  wr_hit;
    cache_line_t           ev_line;
    cache_addr_u           ev_addr;
    int                    cyc;
  } expect_t;

  logic                  clock;
  logic                  reset;
  logic                  rd_search;
  logic [`DC_ADDR_W-1:0] rd_addr;
  logic                  wr_en;
  logic                  wr_from_mem;
  logic                  wr_search;
  logic [`DC_ADDR_W-1:0] wr_addr;
  logic [`DC_DATA_W-1:0] wr_data;
  logic                  wr_dirty;
  logic                  wr_valid;
  logic                  rd_hit;
  logic [`DC_DATA_W-1:0] rd_data;
  logic                  wr_hit;
  logic                  evict_valid;
  logic                  evict_dirty;
  logic [`DC_ADDR_W-1:0] evict_addr;
  logic [`DC_DATA_W-1:0] evict_data;

  cache_line_t            model_line [`DC_NUM_IDX][`DC_NUM_WAY];
  logic [`DC_NUM_IDX-1:0] plru_a;
  logic [`DC_NUM_IDX-1:0] plru_b;
  logic [`DC_NUM_IDX-1:0] plru_c;
  expect_t                exp_q [$];
  int                     cycle_count = 0;
  int                     error_count = 0;
  int                     check_count = 0;
  int                     test_num = 0;
  int                     test_start_errors = 0;
  string                  test_name;

  dcache_top u_dcache_top (.*);

  bind dcache_top dcache_asserts u_asserts (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // read sees the array before this request's write
  function automatic expect_t model_access(logic rd_s, cache_addr_u ra, logic we, logic fm,
                                           logic ws, cache_addr_u wa,
                                           logic [`DC_DATA_W-1:0] wd, logic dirty, logic valid);
    expect_t              e;
    int                   hit_way;
    int                   vic;
    int                   tgt;
    logic [`DC_IDX_W-1:0] ri;
    logic [`DC_IDX_W-1:0] wi;
    e       = '0;
    ri      = ra.fld.set_index;
    wi      = wa.fld.set_index;
    hit_way = -1;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (rd_s && model_line[ri][w].valid && model_line[ri][w].tag == ra.fld.tag) begin
        e.rd_hit  = 1'b1;
        e.rd_data = model_line[ri][w].data;
      end
      if (model_line[wi][w].valid && model_line[wi][w].tag == wa.fld.tag) begin
        hit_way = w;
      end
    end
    e.wr_hit = ws && (hit_way >= 0);
    vic = plru_a[wi] ? (plru_c[wi] ? 3 : 2) : (plru_b[wi] ? 1 : 0);
    tgt = -1;
    if (we && hit_way >= 0) begin
      tgt = hit_way;
    end else if (we && fm) begin
      tgt = vic;
      if (model_line[wi][vic].valid) begin
        e.ev_line               = model_line[wi][vic];
        e.ev_addr.fld.tag       = model_line[wi][vic].tag;
        e.ev_addr.fld.set_index = wi;
      end
      if (plru_a[wi]) begin
        plru_c[wi] = ~plru_c[wi];
      end else begin
        plru_b[wi] = ~plru_b[wi];
      end
      plru_a[wi] = ~plru_a[wi];
    end
    if (tgt >= 0) begin
      model_line[wi][tgt].valid = valid;
      model_line[wi][tgt].dirty = dirty;
      model_line[wi][tgt].tag   = wa.fld.tag;
      model_line[wi][tgt].data  = wd;
    end
    return e;
  endfunction

  function automatic cache_addr_u make_addr(int tag, int set_idx, int ofs);
    cache_addr_u a;
    a.fld.tag       = tag[`DC_TAG_W-1:0];
    a.fld.set_index = set_idx[`DC_IDX_W-1:0];
    a.fld.offset    = ofs[`DC_OFS_W-1:0];
    return a;
  endfunction

  function automatic logic [`DC_DATA_W-1:0] pattern_data(int tag, int set_idx, int salt);
    return {tag[15:0], set_idx[15:0], salt[15:0], 16'ha5c3};
  endfunction

  task automatic report_mismatch(string sig, logic [`DC_DATA_W-1:0] expected,
                                 logic [`DC_DATA_W-1:0] actual);
    error_count++;
    $display("Error at %0t ns: %s expected %h got %h", $time, sig, expected, actual);
  endtask

  task automatic check_read(logic exp_hit, logic [`DC_DATA_W-1:0] exp_data);
    check_count++;
    if (rd_hit !== exp_hit) report_mismatch("rd_hit", 64'(exp_hit), 64'(rd_hit));
    if (rd_data !== exp_data) report_mismatch("rd_data", exp_data, rd_data);
  endtask

  task automatic check_write_hit(logic exp_hit);
    check_count++;
    if (wr_hit !== exp_hit) report_mismatch("wr_hit", 64'(exp_hit), 64'(wr_hit));
  endtask

  task automatic check_evict(cache_line_t exp_line, cache_addr_u exp_addr);
    check_count++;
    if (evict_valid !== exp_line.valid)
      report_mismatch("evict_valid", 64'(exp_line.valid), 64'(evict_valid));
    if (evict_dirty !== exp_line.dirty)
      report_mismatch("evict_dirty", 64'(exp_line.dirty), 64'(evict_dirty));
    if (evict_addr !== exp_addr.raw)
      report_mismatch("evict_addr", 64'(exp_addr.raw), 64'(evict_addr));
    if (evict_data !== exp_line.data) report_mismatch("evict_data", exp_line.data, evict_data);
  endtask

  // results of a request are due once two rising edges have passed
  always @(negedge clock) begin : compare_outputs
    expect_t cur;
    while (exp_q.size() != 0 && exp_q[0].cyc + 2 <= cycle_count) begin
      cur = exp_q.pop_front();
      check_read(cur.rd_hit, cur.rd_data);
      check_write_hit(cur.wr_hit);
      check_evict(cur.ev_line, cur.ev_addr);
    end
  end

  task automatic issue_request(logic rd_s, cache_addr_u ra, logic we, logic fm, logic ws,
                               cache_addr_u wa, logic [`DC_DATA_W-1:0] wd, logic dirty,
                               logic valid);
    expect_t e;
    @(negedge clock);
    rd_search   = rd_s;
    rd_addr     = ra.raw;
    wr_en       = we;
    wr_from_mem = fm;
    wr_search   = ws;
    wr_addr     = wa.raw;
    wr_data     = wd;
    wr_dirty    = dirty;
    wr_valid    = valid;
    e           = model_access(rd_s, ra, we, fm, ws, wa, wd, dirty, valid);
    e.cyc       = cycle_count;
    exp_q.push_back(e);
  endtask

  task automatic read_addr(cache_addr_u a);
    issue_request(1'b1, a, 1'b0, 1'b0, 1'b0, a, '0, 1'b0, 1'b0);
  endtask

  task automatic fill_line(cache_addr_u a, logic [`DC_DATA_W-1:0] d, logic dirty);
    issue_request(1'b0, a, 1'b1, 1'b1, 1'b1, a, d, dirty, 1'b1);
  endtask

  task automatic store_line(cache_addr_u a, logic [`DC_DATA_W-1:0] d, logic dirty, logic valid);
    issue_request(1'b0, a, 1'b1, 1'b0, 1'b1, a, d, dirty, valid);
  endtask

  task automatic start_test(string name);
    test_num++;
    test_name         = name;
    test_start_errors = error_count;
  endtask

  task automatic finish_test();
    @(negedge clock);
    rd_search   = 1'b0;
    wr_en       = 1'b0;
    wr_from_mem = 1'b0;
    wr_search   = 1'b0;
    while (exp_q.size() != 0) @(posedge clock);
    $display("test %0d %s: %s", test_num, test_name,
             (error_count == test_start_errors) ? "ok" : "mismatches");
  endtask

  initial begin : main_sequence
    cache_addr_u a;
    logic [31:0] r;
    void'($urandom(32'h3b5a));
    reset       = 1'b1;
    rd_search   = 1'b0;
    rd_addr     = '0;
    wr_en       = 1'b0;
    wr_from_mem = 1'b0;
    wr_search   = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    wr_dirty    = 1'b0;
    wr_valid    = 1'b0;
    plru_a      = '0;
    plru_b      = '0;
    plru_c      = '0;
    for (int s = 0; s < `DC_NUM_IDX; s++) begin
      for (int w = 0; w < `DC_NUM_WAY; w++) begin
        model_line[s][w] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    start_test("reads after reset");
    for (int i = 0; i < 8; i++) read_addr(make_addr(i * 3 + 1, i, i));
    finish_test();

    // first fill is dirty so its eviction shows the dirty bit
    start_test("four fills in one set");
    for (int i = 1; i <= 4; i++) begin
      fill_line(make_addr(17 * i, 1, 0), pattern_data(17 * i, 1, 0), i == 1);
    end
    for (int i = 1; i <= 4; i++) read_addr(make_addr(17 * i, 1, i));
    finish_test();

    start_test("fills into a full set");
    fill_line(make_addr('h55, 1, 0), pattern_data('h55, 1, 0), 1'b0);
    fill_line(make_addr('h66, 1, 0), pattern_data('h66, 1, 0), 1'b1);
    for (int i = 1; i <= 6; i += 5) read_addr(make_addr(17 * i, 1, 0));
    read_addr(make_addr(34, 1, 0));
    read_addr(make_addr('h55, 1, 0));
    finish_test();

    // set 1 is full and tag 51 sits in its next victim way
    start_test("store hit, store miss, invalidate");
    a = make_addr(51, 1, 1);
    store_line(a, pattern_data(51, 1, 1), 1'b1, 1'b1);
    read_addr(a);
    store_line(make_addr('h71, 1, 0), pattern_data('h71, 1, 1), 1'b1, 1'b1);
    read_addr(make_addr('h71, 1, 0));
    // evicts the stored dirty line only if the tree stayed put
    fill_line(make_addr('h72, 1, 0), pattern_data('h72, 1, 0), 1'b0);
    a = make_addr('h70, 2, 1);
    fill_line(a, pattern_data('h70, 2, 0), 1'b0);
    store_line(a, '0, 1'b0, 1'b0);
    read_addr(a);
    finish_test();

    start_test("read and write at the same edge");
    a = make_addr('h30, 3, 0);
    fill_line(a, pattern_data('h30, 3, 0), 1'b0);
    issue_request(1'b1, a, 1'b1, 1'b0, 1'b1, a, pattern_data('h30, 3, 1), 1'b1, 1'b1);
    read_addr(a);
    finish_test();

    start_test("random mix");
    for (int n = 0; n < 300; n++) begin
      r = $urandom;
      issue_request(r[0], make_addr($urandom % 5, $urandom % 8, $urandom % 8), r[1] | r[2],
                    r[2], r[3], make_addr($urandom % 5, $urandom % 8, $urandom % 8),
                    {$urandom, $urandom}, r[4], r[7:5] != 3'd0);
    end
    finish_test();

    $display("tests: %0d, checks: %0d, errors: %0d", test_num, check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_ifs.sv
src/dcache_req_stage.sv
src/dcache_way.sv
src/dcache_replace.sv
src/dcache_result_stage.sv
src/dcache_top.sv
test/dcache_asserts.sv
test/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module dcache_tb \
  --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
